// File: b200_ctrl_core.f
rtl/core_ctrl_pkg.sv
rtl/ctrl_sid_router.sv
rtl/core_setting_regs.sv
rtl/pps_sync_select.sv
rtl/readback_responder.sv
rtl/b200_ctrl_core.sv
testbench/b200_ctrl_core_assertions.sv
testbench/tb_b200_ctrl_core.sv

// File: rtl/b200_ctrl_core.sv
/* local control core: stream-ID router, setting registers,
   PPS source selection and readback responder on radio_clk */

module b200_ctrl_core #(
    parameter core_ctrl_pkg::sid_t LOCAL_SID = core_ctrl_pkg::L0_CTRL_SID,
    parameter core_ctrl_pkg::sid_t SID_MASK  = core_ctrl_pkg::DEMUX_SID_MASK
) (
    input  logic                     radio_clk,
    input  logic                     i_rst,
    input  logic                     i_cmd_stb,
    input  core_ctrl_pkg::sid_t      i_cmd_sid,
    input  core_ctrl_pkg::set_addr_t i_cmd_addr,
    input  core_ctrl_pkg::set_data_t i_cmd_data,
    input  logic                     i_pps_int,
    input  logic                     i_pps_ext,
    input  logic [31:0]              i_rb_misc,
    output logic [31:0]              o_misc_outs,
    output logic                     o_pps,
    output logic                     o_resp_stb,
    output logic [63:0]              o_resp_data,
    output logic                     o_cmd_drop
);
    import core_ctrl_pkg::*;

    // settings bus from the router
    logic      set_stb;
    set_addr_t set_addr;
    set_data_t set_data;

    // register levels
    rb_sel_t    rb_sel;
    logic [7:0] gpsdo_st;
    logic       pps_sel;

    ////////////////////
    // command routing
    ////////////////////
    ctrl_sid_router #(
        .LOCAL_SID (LOCAL_SID),
        .SID_MASK  (SID_MASK)
    ) router0 (
        .radio_clk  (radio_clk),
        .i_rst      (i_rst),
        .i_cmd_stb  (i_cmd_stb),
        .i_cmd_sid  (i_cmd_sid),
        .i_cmd_addr (i_cmd_addr),
        .i_cmd_data (i_cmd_data),
        .o_set_stb  (set_stb),
        .o_set_addr (set_addr),
        .o_set_data (set_data),
        .o_cmd_drop (o_cmd_drop)
    );

    core_setting_regs regs0 (
        .radio_clk   (radio_clk),
        .i_rst       (i_rst),
        .i_set_stb   (set_stb),
        .i_set_addr  (set_addr),
        .i_set_data  (set_data),
        .o_misc_outs (o_misc_outs),
        .o_rb_sel    (rb_sel),
        .o_gpsdo_st  (gpsdo_st),
        .o_pps_sel   (pps_sel)
    );

    pps_sync_select pps0 (
        .radio_clk (radio_clk),
        .i_pps_int (i_pps_int),
        .i_pps_ext (i_pps_ext),
        .i_pps_sel (pps_sel),
        .o_pps     (o_pps)
    );

    ////////////////////
    // responses
    ////////////////////
    readback_responder resp0 (
        .radio_clk   (radio_clk),
        .i_rst       (i_rst),
        .i_set_stb   (set_stb),
        .i_rb_sel    (rb_sel),
        .i_gpsdo_st  (gpsdo_st),
        .i_rb_misc   (i_rb_misc),
        .o_resp_stb  (o_resp_stb),
        .o_resp_data (o_resp_data)
    );

endmodule

// File: rtl/core_ctrl_pkg.sv
/* types and constants shared by the local control path:
   stream ID, settings bus fields, setting addresses, compat fields
   and the 64-bit readback word with its two decodings */

package core_ctrl_pkg;

    ////////////////////
    // settings bus fields
    ////////////////////
    typedef logic [7:0]  sid_t;
    typedef logic [7:0]  set_addr_t;
    typedef logic [31:0] set_data_t;

    // local control endpoint, upper nibble selects the destination
    localparam sid_t L0_CTRL_SID    = 8'h40;
    localparam sid_t DEMUX_SID_MASK = 8'hf0;

    ////////////////////
    // setting addresses
    ////////////////////
    localparam set_addr_t SR_CORE_MISC     = 8'd16;
    localparam set_addr_t SR_CORE_READBACK = 8'd32;
    localparam set_addr_t SR_CORE_GPSDO_ST = 8'd40;
    localparam set_addr_t SR_CORE_PPS_SEL  = 8'd48;

    ////////////////////
    // readback
    ////////////////////
    typedef logic [1:0] rb_sel_t;

    localparam logic [31:0] COMPAT_SIGNATURE = 32'hace0ba5e;
    localparam logic [15:0] COMPAT_MAJOR     = 16'd3;
    localparam logic [15:0] COMPAT_MINOR     = 16'd0;

    // only radio 0 is built
    localparam logic [7:0] RADIO_STATUS = 8'h01;

    typedef struct packed {
        logic [31:0] signature;
        logic [15:0] major;
        logic [15:0] minor;
    } rb_compat_t;

    typedef struct packed {
        logic [15:0] zero;
        logic [7:0]  radio_st;
        logic [7:0]  gpsdo_st;
        logic [31:0] misc;
    } rb_status_t;

    // one readback word, read either as compat or as status
    typedef union packed {
        rb_compat_t compat;
        rb_status_t status;
    } rb_word_u;

endpackage

// File: rtl/core_setting_regs.sv
/* core setting registers: misc outputs, readback select,
   GPSDO status and PPS source select */

module core_setting_regs (
    input  logic                     radio_clk,
    input  logic                     i_rst,
    input  logic                     i_set_stb,
    input  core_ctrl_pkg::set_addr_t i_set_addr,
    input  core_ctrl_pkg::set_data_t i_set_data,
    output logic [31:0]              o_misc_outs,
    output core_ctrl_pkg::rb_sel_t   o_rb_sel,
    output logic [7:0]               o_gpsdo_st,
    output logic                     o_pps_sel
);
    import core_ctrl_pkg::*;

    // address decode
    logic wr_misc;
    logic wr_rb_sel;
    logic wr_gpsdo;
    logic wr_pps_sel;

    assign wr_misc    = i_set_stb && (i_set_addr == SR_CORE_MISC);
    assign wr_rb_sel  = i_set_stb && (i_set_addr == SR_CORE_READBACK);
    assign wr_gpsdo   = i_set_stb && (i_set_addr == SR_CORE_GPSDO_ST);
    assign wr_pps_sel = i_set_stb && (i_set_addr == SR_CORE_PPS_SEL);

    ////////////////////
    // resettable registers
    ////////////////////
    always_ff @(posedge radio_clk) begin
        if (i_rst) begin
            o_misc_outs <= '0;
            o_rb_sel    <= '0;
            o_pps_sel   <= 1'b0;
        end else begin
            if (wr_misc) begin
                o_misc_outs <= i_set_data;
            end
            if (wr_rb_sel) begin
                o_rb_sel <= i_set_data[1:0];
            end
            // 0 is the internal PPS
            if (wr_pps_sel) begin
                o_pps_sel <= i_set_data[0];
            end
        end
    end

    ////////////////////
    // gpsdo status
    ////////////////////
    // written by host software and kept across a core reset
    always_ff @(posedge radio_clk) begin
        if (wr_gpsdo) begin
            o_gpsdo_st <= i_set_data[7:0];
        end
    end

endmodule

// File: rtl/ctrl_sid_router.sv
/* stream-ID router: local commands become a settings-bus write,
   all others are dropped with a one-cycle pulse */

module ctrl_sid_router #(
    parameter core_ctrl_pkg::sid_t LOCAL_SID = core_ctrl_pkg::L0_CTRL_SID,
    parameter core_ctrl_pkg::sid_t SID_MASK  = core_ctrl_pkg::DEMUX_SID_MASK
) (
    input  logic                     radio_clk,
    input  logic                     i_rst,
    input  logic                     i_cmd_stb,
    input  core_ctrl_pkg::sid_t      i_cmd_sid,
    input  core_ctrl_pkg::set_addr_t i_cmd_addr,
    input  core_ctrl_pkg::set_data_t i_cmd_data,
    output logic                     o_set_stb,
    output core_ctrl_pkg::set_addr_t o_set_addr,
    output core_ctrl_pkg::set_data_t o_set_data,
    output logic                     o_cmd_drop
);

    // only the destination bits of the stream ID take part
    logic sid_match;

    assign sid_match = ((i_cmd_sid & SID_MASK) == LOCAL_SID);

    // strobes
    always_ff @(posedge radio_clk) begin
        if (i_rst) begin
            o_set_stb  <= 1'b0;
            o_cmd_drop <= 1'b0;
        end else begin
            o_set_stb  <= i_cmd_stb & sid_match;
            o_cmd_drop <= i_cmd_stb & ~sid_match;
        end
    end

    // write payload, only meaningful while o_set_stb is high
    always_ff @(posedge radio_clk) begin
        if (i_cmd_stb && sid_match) begin
            o_set_addr <= i_cmd_addr;
            o_set_data <= i_cmd_data;
        end
    end

endmodule

// File: rtl/pps_sync_select.sv
/* PPS synchronizers for the internal and external inputs,
   followed by the source select */

module pps_sync_select (
    input  logic radio_clk,
    input  logic i_pps_int,
    input  logic i_pps_ext,
    input  logic i_pps_sel,
    output logic o_pps
);

    // two flops per input, bit 1 is the synchronized level
    logic [1:0] int_pps_sync;
    logic [1:0] ext_pps_sync;

    always_ff @(posedge radio_clk) begin
        int_pps_sync <= {int_pps_sync[0], i_pps_int};
        ext_pps_sync <= {ext_pps_sync[0], i_pps_ext};
    end

    // select is a quasi-static register level
    assign o_pps = i_pps_sel ? ext_pps_sync[1] : int_pps_sync[1];

endmodule

// File: rtl/readback_responder.sv
/* readback responder: builds the 64-bit word from the select
   and returns it two cycles after the accepted command */

module readback_responder (
    input  logic                   radio_clk,
    input  logic                   i_rst,
    input  logic                   i_set_stb,
    input  core_ctrl_pkg::rb_sel_t i_rb_sel,
    input  logic [7:0]             i_gpsdo_st,
    input  logic [31:0]            i_rb_misc,
    output logic                   o_resp_stb,
    output logic [63:0]            o_resp_data
);
    import core_ctrl_pkg::*;

    // set_stb delayed until the write it carries has landed
    logic     resp_pend;
    rb_word_u rb_word;

    ////////////////////
    // word select
    ////////////////////
    always_comb begin
        rb_word = '0;
        case (i_rb_sel)
            2'd0: begin
                rb_word.compat.signature = COMPAT_SIGNATURE;
                rb_word.compat.major     = COMPAT_MAJOR;
                rb_word.compat.minor     = COMPAT_MINOR;
            end
            2'd2: begin
                rb_word.status.radio_st = RADIO_STATUS;
                rb_word.status.gpsdo_st = i_gpsdo_st;
                rb_word.status.misc     = i_rb_misc;
            end
            // 1 was the SPI readback slot, stays zero
            default: rb_word = '0;
        endcase
    end

    always_ff @(posedge radio_clk) begin
        if (i_rst) begin
            resp_pend  <= 1'b0;
            o_resp_stb <= 1'b0;
        end else begin
            resp_pend  <= i_set_stb;
            o_resp_stb <= resp_pend;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (resp_pend) begin
            o_resp_data <= rb_word;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_b200_ctrl_core \
    --Mdir obj_dir \
    -f b200_ctrl_core.f

status=0
./obj_dir/Vtb_b200_ctrl_core > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: testbench/b200_ctrl_core_assertions.sv
/* concurrent checks on the drop and response strobes of the core,
   bound into every b200_ctrl_core instance */

module b200_ctrl_core_assertions (
    input logic radio_clk,
    input logic i_rst,
    input logic i_cmd_stb,
    input logic o_cmd_drop,
    input logic o_resp_stb
);

    // the response slot of a dropped command sits two cycles after its drop
    drop_without_resp: assert property (@(posedge radio_clk) disable iff (i_rst)
        o_cmd_drop |-> ##2 !o_resp_stb)
        else $error("response strobe seen for a dropped command");

    drop_after_cmd: assert property (@(posedge radio_clk) disable iff (i_rst)
        o_cmd_drop |-> $past(i_cmd_stb))
        else $error("drop pulse without a command one cycle earlier");

    resp_quiet_in_reset: assert property (@(posedge radio_clk)
        i_rst |=> !o_resp_stb)
        else $error("response strobe high during reset");

endmodule

bind b200_ctrl_core b200_ctrl_core_assertions asrt0 (
    .radio_clk  (radio_clk),
    .i_rst      (i_rst),
    .i_cmd_stb  (i_cmd_stb),
    .o_cmd_drop (o_cmd_drop),
    .o_resp_stb (o_resp_stb)
);

// File: testbench/tb_b200_ctrl_core.sv
/* testbench for the local control core: command table with a
   reference model, checks, timeout and summary */

module tb_b200_ctrl_core;
    import core_ctrl_pkg::*;

    localparam int NUM_TESTS   = 13;
    localparam int CYCLE_LIMIT = NUM_TESTS * 8 + 50;

    logic radio_clk, i_rst, i_cmd_stb, i_pps_int, i_pps_ext, o_pps, o_resp_stb, o_cmd_drop;
    sid_t        i_cmd_sid;
    set_addr_t   i_cmd_addr;
    set_data_t   i_cmd_data;
    logic [31:0] i_rb_misc, o_misc_outs;
    logic [63:0] o_resp_data;

    ////////////////////
    // command table
    ////////////////////
    string       tbl_name [NUM_TESTS];
    bit          tbl_rst [NUM_TESTS];
    bit          tbl_b2b [NUM_TESTS];
    bit          tbl_drop [NUM_TESTS];
    sid_t        tbl_sid [NUM_TESTS];
    set_addr_t   tbl_addr [NUM_TESTS];
    set_data_t   tbl_data [NUM_TESTS];
    logic [1:0]  tbl_pps_in [NUM_TESTS];  // {ext, int}
    logic [31:0] tbl_rb_misc [NUM_TESTS];
    rb_word_u    tbl_word [NUM_TESTS];
    logic [31:0] tbl_misc [NUM_TESTS];
    logic        tbl_pps [NUM_TESTS];
    int          test_errors [NUM_TESTS];

    // model of the register state while the table is built
    logic [31:0] m_misc = '0;
    logic [1:0]  m_rb_sel = '0;
    logic [7:0]  m_gpsdo;
    logic        m_pps_sel = 1'b0;
    logic [31:0] lfsr_state = 32'd81828;
    int n_built = 0, check_count = 0, error_count = 0, cycle_count = 0;

    b200_ctrl_core dut0 (.*);

    initial begin
        radio_clk = 1'b0;
        forever #10 radio_clk = ~radio_clk;
    end

    always @(posedge radio_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] value);
        int b;
        value = '0;
        for (b = 0; b < nbits; b++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic add_cmd(input string name, input bit rst, input bit b2b, input bit drop,
                           input sid_t sid, input set_addr_t addr, input set_data_t data,
                           input logic [1:0] pps_in);
        int n;
        rb_word_u word;
        n = n_built;
        // a back-to-back pair shares one misc input level
        if (n > 0 && tbl_b2b[n - 1]) begin
            tbl_rb_misc[n] = tbl_rb_misc[n - 1];
        end else begin
            draw_bits(32, tbl_rb_misc[n]);
        end
        if (rst) begin
            m_misc = '0;
            m_rb_sel = '0;
            m_pps_sel = 1'b0;
        end
        if (!drop) begin
            case (addr)
                SR_CORE_MISC:     m_misc = data;
                SR_CORE_READBACK: m_rb_sel = data[1:0];
                SR_CORE_GPSDO_ST: m_gpsdo = data[7:0];
                SR_CORE_PPS_SEL:  m_pps_sel = data[0];
                default:          ;
            endcase
        end
        word = '0;
        if (m_rb_sel == 2'd0) begin
            word.compat.signature = COMPAT_SIGNATURE;
            word.compat.major     = COMPAT_MAJOR;
            word.compat.minor     = COMPAT_MINOR;
        end else if (m_rb_sel == 2'd2) begin
            word.status.radio_st = RADIO_STATUS;
            word.status.gpsdo_st = m_gpsdo;
            word.status.misc     = tbl_rb_misc[n];
        end
        tbl_name[n]   = name;
        tbl_rst[n]    = rst;
        tbl_b2b[n]    = b2b;
        tbl_drop[n]   = drop;
        tbl_sid[n]    = sid;
        tbl_addr[n]   = addr;
        tbl_data[n]   = data;
        tbl_pps_in[n] = pps_in;
        tbl_word[n] = word;
        tbl_misc[n] = m_misc;
        tbl_pps[n]  = m_pps_sel ? pps_in[1] : pps_in[0];
        test_errors[n] = 0;
        n_built++;
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        add_cmd("compat after reset", 1'b0, 1'b0, 1'b0, 8'h40, 8'd0, 32'd0, 2'b01);
        add_cmd("gpsdo status write", 1'b0, 1'b0, 1'b0, 8'h41, SR_CORE_GPSDO_ST, 32'h5a, 2'b10);
        add_cmd("select status view", 1'b0, 1'b0, 1'b0, 8'h4f, SR_CORE_READBACK, 32'd2, 2'b00);
        draw_bits(32, rnd);
        add_cmd("misc write", 1'b0, 1'b0, 1'b0, 8'h40, SR_CORE_MISC, rnd, 2'b01);
        draw_bits(32, rnd);
        add_cmd("foreign sid dropped", 1'b0, 1'b0, 1'b1, 8'h50, SR_CORE_MISC, rnd, 2'b01);
        add_cmd("pps select external", 1'b0, 1'b0, 1'b0, 8'h40, SR_CORE_PPS_SEL, 32'd1, 2'b10);
        add_cmd("pps follows external", 1'b0, 1'b0, 1'b0, 8'h40, 8'd0, 32'd0, 2'b01);
        add_cmd("status after reset", 1'b1, 1'b0, 1'b0, 8'h40, SR_CORE_READBACK, 32'd2, 2'b01);
        add_cmd("select 1 reads zero", 1'b0, 1'b1, 1'b0, 8'h40, SR_CORE_READBACK, 32'd1, 2'b00);
        add_cmd("select 3 reads zero", 1'b0, 1'b0, 1'b0, 8'h40, SR_CORE_READBACK, 32'd3, 2'b00);
        add_cmd("pair status", 1'b0, 1'b1, 1'b0, 8'h40, SR_CORE_READBACK, 32'd2, 2'b00);
        add_cmd("pair gpsdo write", 1'b0, 1'b0, 1'b0, 8'h40, SR_CORE_GPSDO_ST, 32'ha5, 2'b00);
        add_cmd("zero sid dropped", 1'b0, 1'b0, 1'b1, 8'h00, SR_CORE_GPSDO_ST, 32'hff, 2'b00);
    endtask

    ////////////////////
    // drive and check
    ////////////////////
    task automatic check_value(input int idx, input logic [63:0] actual,
                               input logic [63:0] expected, input string what);
        check_count++;
        if (actual !== expected) begin
            $display("Error at %0t: test %0d %s: got %h, expected %h",
                     $time, idx, what, actual, expected);
            error_count++;
            test_errors[idx]++;
        end
    endtask

    task automatic drive_cmd(input int k);
        i_cmd_stb  = 1'b1;
        i_cmd_sid  = tbl_sid[k];
        i_cmd_addr = tbl_addr[k];
        i_cmd_data = tbl_data[k];
        {i_pps_ext, i_pps_int} = tbl_pps_in[k];
        i_rb_misc  = tbl_rb_misc[k];
    endtask

    task automatic do_reset();
        i_rst = 1'b1;
        i_cmd_stb = 1'b0;
        repeat (5) @(negedge radio_clk);
        i_rst = 1'b0;
    endtask

    // drop due one negedge after the drive and the response three negedges after it
    task automatic run_group(input int first, input int count);
        int s;
        int k;
        for (s = 0; s <= count + 2; s++) begin
            if (s >= 1 && s <= count) begin
                k = first + s - 1;
                check_value(k, 64'(o_cmd_drop), 64'(tbl_drop[k]), "drop strobe");
            end
            // first command's PPS level has just left the second synchronizer flop
            if (s == 2) begin
                check_value(first, 64'(o_pps), 64'(tbl_pps[first]), "selected pps");
            end
            if (s >= 3) begin
                k = first + s - 3;
                check_value(k, 64'(o_resp_stb), 64'(!tbl_drop[k]), "response strobe");
                if (!tbl_drop[k]) begin
                    check_value(k, o_resp_data, 64'(tbl_word[k]), "response word");
                end
            end
            if (s < count) begin
                drive_cmd(first + s);
            end else begin
                i_cmd_stb = 1'b0;
            end
            @(negedge radio_clk);
        end
        k = first + count - 1;
        check_value(k, 64'(o_misc_outs), 64'(tbl_misc[k]), "misc outputs");
    endtask

    initial begin
        int idx;
        int cnt;
        int j;
        int failed_tests;
        {i_rst, i_cmd_stb, i_pps_int, i_pps_ext} = 4'b1000;
        {i_cmd_sid, i_cmd_addr, i_cmd_data, i_rb_misc} = '0;
        failed_tests = 0;
        build_table();
        @(negedge radio_clk);
        do_reset();
        idx = 0;
        while (idx < NUM_TESTS) begin
            if (tbl_rst[idx]) begin
                do_reset();
            end
            cnt = tbl_b2b[idx] ? 2 : 1;
            run_group(idx, cnt);
            for (j = idx; j < idx + cnt; j++) begin
                if (test_errors[j] == 0) begin
                    $display("test %0d %s: ok", j, tbl_name[j]);
                end else begin
                    $display("test %0d %s: %0d errors", j, tbl_name[j], test_errors[j]);
                    failed_tests++;
                end
            end
            idx += cnt;
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
